// ==== dv/fpUnitTb.sv ====
`timescale 1ns/1ps

module fpUnitTb;

    localparam int numRandom = 2000;
    localparam int numDirected = 9;
    localparam int numTests = numRandom + numDirected;
    localparam logic [31:0] qNaN = 32'h7FC0_0000;

    logic clk = 1'b0;
    logic rst;
    logic en;
    logic inValid;
    fpuPkg::fpuOpT inOp;
    fpuPkg::float32T inSrcA;
    fpuPkg::float32T inSrcB;
    corePkg::tagT inTagDst;
    corePkg::regIdxT inNmDst;
    corePkg::sqNT inSqN;
    logic branchTaken;
    corePkg::sqNT branchSqN;
    logic outValid;
    fpuPkg::wordT outResult;
    corePkg::tagT outTagDst;
    corePkg::regIdxT outNmDst;
    corePkg::sqNT outSqN;

    logic [31:0] lcgState;
    logic [31:0] specials [12];
    logic [50:0] expQ [$];
    logic [50:0] head;
    corePkg::sqNT sqDiff;
    int errors = 0;
    int checks = 0;

    fpUnit u_dut (
        .clk(clk),
        .rst(rst),
        .en(en),
        .inValid(inValid),
        .inOp(inOp),
        .inSrcA(inSrcA),
        .inSrcB(inSrcB),
        .inTagDst(inTagDst),
        .inNmDst(inNmDst),
        .inSqN(inSqN),
        .branchTaken(branchTaken),
        .branchSqN(branchSqN),
        .outValid(outValid),
        .outResult(outResult),
        .outTagDst(outTagDst),
        .outNmDst(outNmDst),
        .outSqN(outSqN)
    );

    always #4 clk = ~clk;

    // ********************
    // Reference model
    // ********************
    function automatic logic isNaN(input logic [31:0] x);
        return (x[30:23] == 8'hFF) && (x[22:0] != 23'd0);
    endfunction

    function automatic logic [31:0] mulRef(input logic [31:0] a, input logic [31:0] b);
        logic s;
        int e;
        logic [47:0] p;
        logic [24:0] m;
        logic st;
        s = a[31] ^ b[31];
        if (isNaN(a) || isNaN(b)) return qNaN;
        if (a[30:23] == 8'hFF || b[30:23] == 8'hFF) begin
            if (a[30:23] == 8'd0 || b[30:23] == 8'd0) return qNaN;
            return {s, 8'hFF, 23'd0};
        end
        if (a[30:23] == 8'd0 || b[30:23] == 8'd0) return {s, 31'd0};
        p = {24'd0, 1'b1, a[22:0]} * {24'd0, 1'b1, b[22:0]};
        e = int'(a[30:23]) + int'(b[30:23]) - 127;
        st = 1'b0;
        if (p[47]) begin
            st = p[0];
            p = p >> 1;
            e = e + 1;
        end
        st = st | (|p[21:0]);
        m = {2'b01, p[45:23]};
        if (p[22] && (st || m[0])) m = m + 25'd1;
        if (m[24]) begin
            m = m >> 1;
            e = e + 1;
        end
        if (e >= 255) return {s, 8'hFF, 23'd0};
        if (e <= 0) return {s, 31'd0};
        return {s, 8'(e), m[22:0]};
    endfunction

    function automatic logic [31:0] intToFloat(input logic [31:0] x, input logic sgn);
        logic neg;
        logic [31:0] m;
        logic [24:0] sig;
        int e;
        neg = sgn && x[31];
        m = neg ? -x : x;
        if (m == 32'd0) return 32'd0;
        e = 31;
        while (!m[31]) begin
            m = m << 1;
            e = e - 1;
        end
        sig = {1'b0, m[31:8]};
        if (m[7] && ((|m[6:0]) || m[8])) sig = sig + 25'd1;
        // Carry out leaves a zero fraction.
        if (sig[24]) e = e + 1;
        return {neg, 8'(e + 127), sig[22:0]};
    endfunction

    function automatic logic [31:0] floatToInt(input logic [31:0] x, input logic sgn);
        int e;
        int sh;
        longint sig;
        longint mag;
        longint rem;
        longint half;
        if (isNaN(x)) return sgn ? 32'h7FFF_FFFF : 32'hFFFF_FFFF;
        e = int'(x[30:23]) - 127;
        sig = longint'({1'b1, x[22:0]});
        if (e < -1) begin
            mag = 64'sd0;
        end else if (e >= 32) begin
            mag = 64'sh2_0000_0000;
        end else if (e >= 23) begin
            mag = sig << (e - 23);
        end else begin
            sh = 23 - e;
            mag = sig >>> sh;
            rem = sig & ((64'sd1 << sh) - 64'sd1);
            half = 64'sd1 << (sh - 1);
            if (rem > half || (rem == half && mag[0])) mag = mag + 64'sd1;
        end
        if (sgn) begin
            if (x[31]) return (mag > 64'sh8000_0000) ? 32'h8000_0000 : 32'(-mag);
            return (mag > 64'sh7FFF_FFFF) ? 32'h7FFF_FFFF : 32'(mag);
        end
        if (x[31]) return 32'd0;
        return (mag > 64'shFFFF_FFFF) ? 32'hFFFF_FFFF : 32'(mag);
    endfunction

    function automatic logic [31:0] refResult(input fpuPkg::fpuOpT op, input logic [31:0] a,
                                              input logic [31:0] b);
        logic lt;
        logic eq;
        longint ka;
        longint kb;
        // Subnormals and both zeros give a key of zero.
        ka = (a[30:23] == 8'd0) ? 64'sd0 : longint'(a[30:0]);
        kb = (b[30:23] == 8'd0) ? 64'sd0 : longint'(b[30:0]);
        if (a[31]) ka = -ka;
        if (b[31]) kb = -kb;
        lt = !(isNaN(a) || isNaN(b)) && (ka < kb);
        eq = !(isNaN(a) || isNaN(b)) && (ka == kb);
        case (op)
            fpuPkg::opFMul: return mulRef(a, b);
            fpuPkg::opFEq: return {31'd0, eq};
            fpuPkg::opFLt: return {31'd0, lt};
            fpuPkg::opFLe: return {31'd0, lt | eq};
            fpuPkg::opFMin: return lt ? a : b;
            fpuPkg::opFMax: return lt ? b : a;
            fpuPkg::opFSgnj: return {b[31], a[30:0]};
            fpuPkg::opFSgnjn: return {~b[31], a[30:0]};
            fpuPkg::opFSgnjx: return {a[31] ^ b[31], a[30:0]};
            fpuPkg::opFCvtWS: return floatToInt(a, 1'b1);
            fpuPkg::opFCvtWuS: return floatToInt(a, 1'b0);
            fpuPkg::opFCvtSW: return intToFloat(a, 1'b1);
            fpuPkg::opFCvtSWu: return intToFloat(a, 1'b0);
            default: return 32'd0;
        endcase
    endfunction

    // ********************
    // Stimulus helpers
    // ********************
    function logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function logic [31:0] pickOperand();
        logic [31:0] r;
        logic [31:0] m;
        r = nextRand();
        m = nextRand();
        case (r[31:30])
            2'd0: return specials[int'(r[7:0]) % 12];
            2'd1: return m;
            // Exponents near the integer range.
            default: return {r[0], 8'd110 + {2'b00, r[29:24]}, m[22:0]};
        endcase
    endfunction

    task automatic issue(input fpuPkg::fpuOpT op, input logic [31:0] a, input logic [31:0] b,
                         input logic valid, input logic enable, input logic taken,
                         input corePkg::sqNT sq, input corePkg::sqNT bsq);
        logic [31:0] r;
        r = nextRand();
        @(posedge clk);
        #1;
        inValid = valid;
        en = enable;
        inOp = op;
        inSrcA = a;
        inSrcB = b;
        inTagDst = r[6:0];
        inNmDst = r[11:7];
        inSqN = sq;
        branchTaken = taken;
        branchSqN = bsq;
    endtask

    // ********************
    // Expected results and checking
    // ********************
    assign sqDiff = inSqN - branchSqN;

    always @(posedge clk) begin
        if (!rst && inValid && en && (!branchTaken || $signed(sqDiff) <= 7'sd0)) begin
            expQ.push_back({refResult(inOp, inSrcA, inSrcB), inTagDst, inNmDst, inSqN});
        end
    end

    always @(negedge clk) begin
        if (!rst) begin
            if (expQ.size() == 0) begin
                if (outValid !== 1'b0) begin
                    errors++;
                    $display("mismatch at %0t: outValid high with no pending micro-op", $time);
                end
            end else begin
                head = expQ.pop_front();
                checks++;
                if (outValid !== 1'b1) begin
                    errors++;
                    $display("mismatch at %0t: no outValid for sqN %0d", $time, head[6:0]);
                end else if ({outResult, outTagDst, outNmDst, outSqN} !== head) begin
                    errors++;
                    $display("mismatch at %0t: got %h %0d %0d %0d, expected %h %0d %0d %0d",
                             $time, outResult, outTagDst, outNmDst, outSqN,
                             head[50:19], head[18:12], head[11:7], head[6:0]);
                end
            end
        end
    end

    initial begin
        #((numTests + 20) * 8);
        $display("Timeout: run did not finish within %0d cycles", numTests + 20);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        lcgState = 32'd4267;
        specials = '{32'h0000_0000, 32'h8000_0000, 32'h7F80_0000, 32'hFF80_0000,
                     32'h7FC0_0000, 32'h7F80_0001, 32'h3F80_0000, 32'h4F00_0000,
                     32'h0000_0001, 32'h0100_0001, 32'h4020_0000, 32'h4060_0000};
        rst = 1'b1;
        en = 1'b0;
        inValid = 1'b0;
        inOp = '0;
        inSrcA = '0;
        inSrcB = '0;
        inTagDst = '0;
        inNmDst = '0;
        inSqN = '0;
        branchTaken = 1'b0;
        branchSqN = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        // Idle cycles keep outValid low.
        repeat (3) @(posedge clk);

        // Ties, saturation, signed zeros, unordered and branch age.
        issue(fpuPkg::opFCvtSW, 32'h0100_0001, 32'd0, 1'b1, 1'b1, 1'b0, 7'd1, 7'd0);
        issue(fpuPkg::opFCvtWS, 32'h4020_0000, 32'd0, 1'b1, 1'b1, 1'b0, 7'd2, 7'd0);
        issue(fpuPkg::opFCvtWuS, 32'hBFC0_0000, 32'd0, 1'b1, 1'b1, 1'b0, 7'd3, 7'd0);
        issue(fpuPkg::opFEq, 32'h0000_0000, 32'h8000_0000, 1'b1, 1'b1, 1'b0, 7'd4, 7'd0);
        issue(fpuPkg::opFLt, 32'h7FC0_0000, 32'h3F80_0000, 1'b1, 1'b1, 1'b0, 7'd5, 7'd0);
        issue(fpuPkg::opFCvtWS, 32'h4F00_0000, 32'd0, 1'b1, 1'b1, 1'b0, 7'd6, 7'd0);
        issue(fpuPkg::opFMul, 32'h3F80_0000, 32'h4000_0000, 1'b1, 1'b1, 1'b1, 7'd2, 7'd126);
        issue(fpuPkg::opFMul, 32'h3F80_0000, 32'h4000_0000, 1'b1, 1'b1, 1'b1, 7'd126, 7'd2);
        issue(fpuPkg::opFMax, 32'h3F80_0000, 32'h4000_0000, 1'b1, 1'b1, 1'b1, 7'd5, 7'd5);

        for (int i = 0; i < numRandom; i++) begin
            a = pickOperand();
            b = pickOperand();
            r = nextRand();
            issue(4'(int'(r[7:0]) % 13), a, b, r[31:29] != 3'd0, r[11:8] != 4'd0,
                  r[14:12] == 3'd0, r[21:15], r[28:22]);
        end

        @(posedge clk);
        #1;
        inValid = 1'b0;
        repeat (3) @(posedge clk);
        if (expQ.size() != 0) begin
            errors++;
            $display("Results still pending at the end of the run: %0d", expQ.size());
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
verilog/corePkg.sv
verilog/fpuPkg.sv
verilog/fpCompare.sv
verilog/fpMultiply.sv
verilog/fpIntConvert.sv
verilog/fpUnit.sv
dv/fpUnitTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module fpUnitTb -f filelist.f -o simv
./obj_dir/simv | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL: see sim.log"
exit 1

// ==== verilog/corePkg.sv ====
package corePkg;

    // ********************
    // Bookkeeping widths
    // ********************
    localparam int sqNWidth = 7;
    localparam int tagWidth = 7;
    localparam int regIdxWidth = 5;

    // ********************
    // Micro-op fields
    // ********************

    // Sequence number.
    // Age is taken from the signed difference, so wrap-around is harmless.
    typedef logic [sqNWidth-1:0] sqNT;

    // Physical destination register tag.
    typedef logic [tagWidth-1:0] tagT;

    // Architectural destination register.
    typedef logic [regIdxWidth-1:0] regIdxT;

endpackage

// ==== verilog/fpCompare.sv ====
`timescale 1ns/1ps

module fpCompare (
    input  fpuPkg::float32T a,
    input  fpuPkg::float32T b,
    output logic lessThan,
    output logic equal,
    output logic unordered
);

    fpuPkg::expT expA;
    fpuPkg::expT expB;
    fpuPkg::mantT mantA;
    fpuPkg::mantT mantB;
    logic [30:0] magA;
    logic [30:0] magB;
    logic signA;
    logic signB;

    assign expA = a[30:23];
    assign expB = b[30:23];
    assign mantA = a[22:0];
    assign mantB = b[22:0];

    assign unordered = ((expA == 8'hFF) && (mantA != '0))
                    || ((expB == 8'hFF) && (mantB != '0));

    // Subnormals flush to zero; zeros count as positive.
    assign magA = (expA == '0) ? '0 : a[30:0];
    assign magB = (expB == '0) ? '0 : b[30:0];
    assign signA = a[31] & (magA != '0);
    assign signB = b[31] & (magB != '0);

    always_comb begin
        lessThan = 1'b0;
        equal = 1'b0;
        if (!unordered) begin
            equal = (signA == signB) && (magA == magB);
            if (signA != signB) begin
                lessThan = signA;
            end else if (signA) begin
                // With both negative the larger magnitude is smaller.
                lessThan = magA > magB;
            end else begin
                lessThan = magA < magB;
            end
        end
    end

endmodule

// ==== verilog/fpIntConvert.sv ====
`timescale 1ns/1ps

module fpIntConvert (
    input  fpuPkg::wordT src,
    input  logic signedMode,
    input  logic toFloat,
    output fpuPkg::wordT convResult
);

    logic intNeg;
    fpuPkg::wordT intMag;
    logic [4:0] msbPos;
    fpuPkg::wordT intNorm;
    logic intRoundUp;
    logic [24:0] intSigRound;
    fpuPkg::expT intExp;
    fpuPkg::float32T fromInt;

    logic fltSign;
    fpuPkg::expT fltExp;
    fpuPkg::mantT fltMant;
    logic fltNaN;
    logic fltBig;
    logic fltSmall;
    logic [5:0] fltShift;
    logic [63:0] fltFixed;
    logic fltRoundUp;
    logic [32:0] fltMag;
    fpuPkg::wordT toInt;

    // ********************
    // Integer to float
    // ********************
    assign intNeg = signedMode & src[31];
    assign intMag = intNeg ? (~src + 32'd1) : src;

    always_comb begin
        msbPos = '0;
        for (int i = 0; i < 32; i++) begin
            if (intMag[i]) begin
                msbPos = 5'(i);
            end
        end
    end

    // Leading one moves to bit 31; bits 7:0 are dropped and rounded.
    assign intNorm = intMag << (5'd31 - msbPos);
    assign intRoundUp = intNorm[7] & ((|intNorm[6:0]) | intNorm[8]);
    assign intSigRound = {1'b0, intNorm[31:8]} + 25'(intRoundUp);
    assign intExp = 8'(fpuPkg::expBias) + {3'b0, msbPos} + {7'b0, intSigRound[24]};
    assign fromInt = (intMag == '0) ? '0 : {intNeg, intExp, intSigRound[22:0]};

    // ********************
    // Float to integer
    // ********************
    assign fltSign = src[31];
    assign fltExp = src[30:23];
    assign fltMant = src[22:0];
    assign fltNaN = (fltExp == 8'hFF) && (fltMant != '0);
    // Infinity and everything from 2^32 up cannot fit.
    assign fltBig = fltExp >= 8'd159;
    // Below 0.5 the value rounds to zero.
    assign fltSmall = fltExp < 8'd126;

    // Fixed point with 32 fraction bits.
    assign fltShift = 6'(fltExp - 8'd118);
    assign fltFixed = {40'b0, 1'b1, fltMant} << fltShift;
    assign fltRoundUp = fltFixed[31] & ((|fltFixed[30:0]) | fltFixed[32]);
    assign fltMag = fltSmall ? '0 : ({1'b0, fltFixed[63:32]} + 33'(fltRoundUp));

    always_comb begin
        if (fltNaN) begin
            toInt = signedMode ? fpuPkg::intMaxSigned : fpuPkg::intMaxUnsigned;
        end else if (signedMode) begin
            if (fltBig) begin
                toInt = fltSign ? fpuPkg::intMinSigned : fpuPkg::intMaxSigned;
            end else if (fltSign) begin
                toInt = (fltMag > 33'h0_8000_0000) ? fpuPkg::intMinSigned
                                                   : (~fltMag[31:0] + 32'd1);
            end else begin
                toInt = (fltMag > 33'h0_7FFF_FFFF) ? fpuPkg::intMaxSigned : fltMag[31:0];
            end
        end else begin
            if (fltSign) begin
                toInt = '0;
            end else if (fltBig || fltMag[32]) begin
                toInt = fpuPkg::intMaxUnsigned;
            end else begin
                toInt = fltMag[31:0];
            end
        end
    end

    assign convResult = toFloat ? fromInt : toInt;

endmodule

// ==== verilog/fpMultiply.sv ====
`timescale 1ns/1ps

module fpMultiply (
    input  fpuPkg::float32T a,
    input  fpuPkg::float32T b,
    output fpuPkg::float32T product
);

    logic signP;
    fpuPkg::expT expA;
    fpuPkg::expT expB;
    fpuPkg::mantT mantA;
    fpuPkg::mantT mantB;
    logic aNaN;
    logic bNaN;
    logic aInf;
    logic bInf;
    logic aZero;
    logic bZero;
    logic [47:0] sigProd;
    logic norm;
    fpuPkg::mantT mantNorm;
    logic guard;
    logic sticky;
    logic roundUp;
    logic [24:0] sigRound;
    logic [9:0] expSum;
    logic [9:0] expFinal;
    logic overflow;
    logic underflow;

    assign signP = a[31] ^ b[31];
    assign expA = a[30:23];
    assign expB = b[30:23];
    assign mantA = a[22:0];
    assign mantB = b[22:0];

    assign aNaN = (expA == 8'hFF) && (mantA != '0);
    assign bNaN = (expB == 8'hFF) && (mantB != '0);
    assign aInf = (expA == 8'hFF) && (mantA == '0);
    assign bInf = (expB == 8'hFF) && (mantB == '0);
    // Zero exponent covers subnormals too.
    assign aZero = (expA == '0);
    assign bZero = (expB == '0);

    // Product lies in [1, 4), so at most one position of normalization.
    assign sigProd = {1'b1, mantA} * {1'b1, mantB};
    assign norm = sigProd[47];
    assign mantNorm = norm ? sigProd[46:24] : sigProd[45:23];
    assign guard = norm ? sigProd[23] : sigProd[22];
    assign sticky = norm ? |sigProd[22:0] : |sigProd[21:0];

    // Round to nearest with ties to even.
    assign roundUp = guard & (sticky | mantNorm[0]);
    assign sigRound = {2'b01, mantNorm} + 25'(roundUp);

    assign expSum = {2'b00, expA} + {2'b00, expB} + {9'b0, norm} - 10'(fpuPkg::expBias);
    assign expFinal = expSum + {9'b0, sigRound[24]};
    assign overflow = $signed(expFinal) >= 10'sd255;
    assign underflow = $signed(expFinal) <= 10'sd0;

    always_comb begin
        if (aNaN || bNaN || (aInf && bZero) || (aZero && bInf)) begin
            product = fpuPkg::canonicalNaN;
        end else if (aInf || bInf) begin
            product = {signP, 8'hFF, 23'b0};
        end else if (aZero || bZero || underflow) begin
            product = {signP, 31'b0};
        end else if (overflow) begin
            product = {signP, 8'hFF, 23'b0};
        end else begin
            // On carry-out the low bits are already zero.
            product = {signP, expFinal[7:0], sigRound[22:0]};
        end
    end

endmodule

// ==== verilog/fpUnit.sv ====
`timescale 1ns/1ps

module fpUnit (
    input  logic clk,
    input  logic rst,
    input  logic en,
    input  logic inValid,
    input  fpuPkg::fpuOpT inOp,
    input  fpuPkg::float32T inSrcA,
    input  fpuPkg::float32T inSrcB,
    input  corePkg::tagT inTagDst,
    input  corePkg::regIdxT inNmDst,
    input  corePkg::sqNT inSqN,
    input  logic branchTaken,
    input  corePkg::sqNT branchSqN,
    output logic outValid,
    output fpuPkg::wordT outResult,
    output corePkg::tagT outTagDst,
    output corePkg::regIdxT outNmDst,
    output corePkg::sqNT outSqN
);

    logic lessThan;
    logic equal;
    logic unordered;
    fpuPkg::float32T product;
    logic signedMode;
    logic toFloat;
    fpuPkg::wordT convResult;
    fpuPkg::wordT result;
    corePkg::sqNT sqDiff;
    logic accept;

    fpCompare compare (
        .a(inSrcA),
        .b(inSrcB),
        .lessThan(lessThan),
        .equal(equal),
        .unordered(unordered)
    );

    fpMultiply multiply (
        .a(inSrcA),
        .b(inSrcB),
        .product(product)
    );

    assign signedMode = (inOp == fpuPkg::opFCvtWS) || (inOp == fpuPkg::opFCvtSW);
    assign toFloat = (inOp == fpuPkg::opFCvtSW) || (inOp == fpuPkg::opFCvtSWu);

    fpIntConvert convert (
        .src(inSrcA),
        .signedMode(signedMode),
        .toFloat(toFloat),
        .convResult(convResult)
    );

    // ********************
    // Result select
    // ********************
    always_comb begin
        case (inOp)
            fpuPkg::opFMul: result = product;
            fpuPkg::opFEq: result = {31'b0, equal & ~unordered};
            fpuPkg::opFLt: result = {31'b0, lessThan & ~unordered};
            fpuPkg::opFLe: result = {31'b0, (lessThan | equal) & ~unordered};
            fpuPkg::opFMin: result = lessThan ? inSrcA : inSrcB;
            fpuPkg::opFMax: result = lessThan ? inSrcB : inSrcA;
            fpuPkg::opFSgnj: result = {inSrcB[31], inSrcA[30:0]};
            fpuPkg::opFSgnjn: result = {~inSrcB[31], inSrcA[30:0]};
            fpuPkg::opFSgnjx: result = {inSrcA[31] ^ inSrcB[31], inSrcA[30:0]};
            fpuPkg::opFCvtWS,
            fpuPkg::opFCvtWuS,
            fpuPkg::opFCvtSW,
            fpuPkg::opFCvtSWu: result = convResult;
            default: result = '0;
        endcase
    end

    // Drop anything younger than a taken branch.
    assign sqDiff = inSqN - branchSqN;
    assign accept = en && inValid && (!branchTaken || ($signed(sqDiff) <= 7'sd0));

    // ********************
    // Result register
    // ********************
    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else begin
            outValid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            outResult <= result;
            outTagDst <= inTagDst;
            outNmDst <= inNmDst;
            outSqN <= inSqN;
        end
    end

endmodule

// ==== verilog/fpuPkg.sv ====
package fpuPkg;

    // ********************
    // Formats
    // ********************
    typedef logic [31:0] float32T;
    typedef logic [31:0] wordT;
    typedef logic [7:0] expT;
    typedef logic [22:0] mantT;
    typedef logic [3:0] fpuOpT;

    // ********************
    // Opcodes
    // ********************
    localparam fpuOpT opFMul    = 4'd0;
    localparam fpuOpT opFEq     = 4'd1;
    localparam fpuOpT opFLt     = 4'd2;
    localparam fpuOpT opFLe     = 4'd3;
    localparam fpuOpT opFMin    = 4'd4;
    localparam fpuOpT opFMax    = 4'd5;
    localparam fpuOpT opFSgnj   = 4'd6;
    localparam fpuOpT opFSgnjn  = 4'd7;
    localparam fpuOpT opFSgnjx  = 4'd8;
    localparam fpuOpT opFCvtWS  = 4'd9;
    localparam fpuOpT opFCvtWuS = 4'd10;
    localparam fpuOpT opFCvtSW  = 4'd11;
    localparam fpuOpT opFCvtSWu = 4'd12;

    // ********************
    // Constants
    // ********************
    localparam int expBias = 127;
    localparam float32T canonicalNaN = 32'h7FC0_0000;
    // Saturation values for float to integer.
    localparam wordT intMaxSigned = 32'h7FFF_FFFF;
    localparam wordT intMinSigned = 32'h8000_0000;
    localparam wordT intMaxUnsigned = 32'hFFFF_FFFF;

endpackage
